//--- design/sat_types_pkg.sv
// SAT check engine encoding types
// widths of the problem, literal and assignment encodings,
// and the layout of a packed clause-table row
package sat_types_pkg;

    localparam int VAR_ADDR_W = 6;   // 64 variables
    localparam int NSAT       = 3;   // literals per clause
    localparam int SLOTS      = 4;   // clauses packed per row
    localparam int ROW_W      = 6;   // 64 clause rows

    typedef logic [VAR_ADDR_W-1:0] var_addr_t;
    typedef logic [ROW_W-1:0]      row_idx_t;
    typedef logic [SLOTS-1:0]      slot_mask_t;   // one enable per slot

    // literal = variable plus negation bit, also the translate-table index
    typedef struct packed {
        var_addr_t var_addr;
        logic      neg;         // 1 = negated literal
    } literal_t;

    // per-variable value, 2'b11 never stored
    typedef enum logic [1:0] {
        UNASSIGNED = 2'd0,
        VAL_FALSE  = 2'd1,
        VAL_TRUE   = 2'd2
    } assign_e;

    // the other NSAT-1 literals of one clause
    typedef struct packed {
        literal_t [NSAT-2:0] lit;
    } clause_slot_t;

    typedef clause_slot_t [SLOTS-1:0] clause_row_t;   // 56 bits by default

    typedef struct packed {
        row_idx_t   row;    // clause row holding this literal's clauses
        slot_mask_t mask;   // slots that belong to this literal
    } xlat_entry_t;

    typedef enum logic [1:0] {
        LIT_FALSE = 2'd0,
        LIT_TRUE  = 2'd1,
        LIT_OPEN  = 2'd2
    } lit_status_e;

endpackage

//--- design/sat_msg_pkg.sv
// SAT check engine messages
// host write requests and the per-query result record
package sat_msg_pkg;

    // address must hold a full literal, data a full clause row
    localparam int HOST_ADDR_W = $bits(sat_types_pkg::literal_t);
    localparam int HOST_DATA_W = $bits(sat_types_pkg::clause_row_t);

    // store selected by a host write
    typedef enum logic [1:0] {
        TGT_XLAT   = 2'd0,   // literal translation table, addr = literal
        TGT_CLAUSE = 2'd1,   // clause table, addr = row index
        TGT_ASSIGN = 2'd2    // assignment store, addr = variable
    } wr_target_e;

    typedef struct packed {
        wr_target_e             target;
        logic [HOST_ADDR_W-1:0] addr;
        logic [HOST_DATA_W-1:0] data;   // low bits used for narrow stores
    } host_wr_t;

    // reduced outcome of one query
    typedef struct packed {
        logic                    conflict;        // some enabled clause fully false
        logic [2:0]              unit_count;      // clauses left with one open literal
        logic                    implied_valid;
        sat_types_pkg::literal_t implied_lit;     // from lowest unit slot
    } result_t;

endpackage

//--- design/lit_translate_table.sv
// literal translation table
// maps each literal to its clause-table row and slot mask,
// registered read, contents cleared at reset
`timescale 1ns/1ps

module lit_translate_table #(
    parameter int VAR_ADDR_W = sat_types_pkg::VAR_ADDR_W,
    parameter int SLOTS      = sat_types_pkg::SLOTS
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       we_i,
    input  sat_types_pkg::literal_t    wr_lit_i,
    input  sat_types_pkg::xlat_entry_t wr_entry_i,
    input  logic                       rd_en_i,
    input  sat_types_pkg::literal_t    rd_lit_i,
    output sat_types_pkg::xlat_entry_t entry_o
);
    import sat_types_pkg::*;

    localparam int DEPTH = 2 ** (VAR_ADDR_W + 1);   // both polarities of every variable

    xlat_entry_t mem_q [DEPTH];

    // parameters must agree with the package encoding
    if ($bits(literal_t) != VAR_ADDR_W + 1 || $bits(slot_mask_t) != SLOTS) begin : g_chk
        $error("lit_translate_table: parameters differ from sat_types_pkg");
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;         // zero mask = literal in no clause
            end
            entry_o <= '0;
        end else begin
            if (we_i) begin
                mem_q[wr_lit_i] <= wr_entry_i;
            end
            if (rd_en_i) begin
                entry_o <= mem_q[rd_lit_i];   // edge 1 of the query pipe
            end
        end
    end

endmodule

//--- design/clause_table.sv
// clause table
// simple dual-port row memory, each row packs SLOTS clauses;
// written only in LOAD mode so it acts as a ROM while queries run
// the slot mask rides along so it lines up with its row
`timescale 1ns/1ps

module clause_table #(
    parameter int SLOTS = sat_types_pkg::SLOTS,
    parameter int ROW_W = sat_types_pkg::ROW_W
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       we_i,
    input  sat_types_pkg::row_idx_t    wr_row_i,
    input  sat_types_pkg::clause_row_t wr_data_i,
    input  logic                       rd_en_i,
    input  sat_types_pkg::row_idx_t    rd_row_i,
    input  sat_types_pkg::slot_mask_t  mask_i,
    output sat_types_pkg::clause_row_t row_o,
    output sat_types_pkg::slot_mask_t  mask_o
);
    import sat_types_pkg::*;

    localparam int DEPTH = 2 ** ROW_W;

    clause_row_t mem_q [DEPTH];

    if ($bits(row_idx_t) != ROW_W || $bits(slot_mask_t) != SLOTS) begin : g_chk
        $error("clause_table: parameters differ from sat_types_pkg");
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
            row_o  <= '0;
            mask_o <= '0;   // nothing enabled until a real lookup
        end else begin
            // table writes and lookups never overlap, so no bypass path
            if (we_i) begin
                mem_q[wr_row_i] <= wr_data_i;
            end
            if (rd_en_i) begin
                row_o  <= mem_q[rd_row_i];   // edge 2
                mask_o <= mask_i;            // delayed with its row
            end
        end
    end

endmodule

//--- design/assign_store.sv
// assignment store
// one value per variable, UNASSIGNED after reset; every literal of
// the current clause row is turned into false / true / open in parallel
`timescale 1ns/1ps

module assign_store #(
    parameter int VAR_ADDR_W = sat_types_pkg::VAR_ADDR_W,
    parameter int SLOTS      = sat_types_pkg::SLOTS
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       we_i,
    input  sat_types_pkg::var_addr_t   wr_var_i,
    input  sat_types_pkg::assign_e     wr_val_i,
    input  sat_types_pkg::clause_row_t row_i,
    output sat_types_pkg::lit_status_e [SLOTS-1:0][sat_types_pkg::NSAT-2:0] status_o
);
    import sat_types_pkg::*;

    localparam int NVARS = 2 ** VAR_ADDR_W;

    assign_e val_q [NVARS];

    // true when assigned and value differs from the negation bit
    function automatic lit_status_e lit_status(assign_e val, logic neg);
        if (val == UNASSIGNED) begin
            return LIT_OPEN;
        end
        return ((val == VAL_TRUE) != neg) ? LIT_TRUE : LIT_FALSE;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int v = 0; v < NVARS; v++) begin
                val_q[v] <= UNASSIGNED;
            end
        end else if (we_i) begin
            val_q[wr_var_i] <= wr_val_i;   // visible from the next edge
        end
    end

    // combinational lookup, clause_eval samples it at edge 3
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            for (int l = 0; l < NSAT - 1; l++) begin
                status_o[s][l] = lit_status(val_q[row_i[s].lit[l].var_addr],
                                            row_i[s].lit[l].neg);
            end
        end
    end

    // host data is a raw vector upstream, catch the unused code 2'b11
    a_legal_value : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        we_i |-> wr_val_i inside {UNASSIGNED, VAL_FALSE, VAL_TRUE})
        else $error("assign_store: illegal assignment encoding %b", wr_val_i);

endmodule

//--- design/clause_eval.sv
// clause evaluator
// classifies each enabled slot as conflict or unit, counts the unit
// slots, picks the implied literal of the lowest unit slot and
// registers the reduced result
`timescale 1ns/1ps

module clause_eval #(
    parameter int SLOTS = sat_types_pkg::SLOTS
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       en_i,
    input  sat_types_pkg::clause_row_t row_i,
    input  sat_types_pkg::slot_mask_t  mask_i,
    input  sat_types_pkg::lit_status_e [SLOTS-1:0][sat_types_pkg::NSAT-2:0] status_i,
    output sat_msg_pkg::result_t       result_o
);
    import sat_types_pkg::*;
    import sat_msg_pkg::*;

    logic     [SLOTS-1:0] conflict_s;   // both other literals false
    logic     [SLOTS-1:0] unit_s;       // one false, one open
    literal_t [SLOTS-1:0] open_lit;     // candidate implied literal per slot
    result_t              res_d;

    // per-slot status, masked-off slots never report
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            conflict_s[s] = mask_i[s]
                         && status_i[s][0] == LIT_FALSE
                         && status_i[s][1] == LIT_FALSE;
            unit_s[s]     = mask_i[s]
                         && ((status_i[s][0] == LIT_FALSE && status_i[s][1] == LIT_OPEN)
                          || (status_i[s][0] == LIT_OPEN  && status_i[s][1] == LIT_FALSE));
            // only one literal can be open in a unit slot
            open_lit[s]   = (status_i[s][0] == LIT_OPEN) ? row_i[s].lit[0] : row_i[s].lit[1];
        end
    end

    // reduce over slots
    always_comb begin
        res_d          = '0;
        res_d.conflict = |conflict_s;
        // walk downwards so the lowest unit slot writes last
        for (int s = SLOTS - 1; s >= 0; s--) begin
            res_d.unit_count = res_d.unit_count + 3'(unit_s[s]);
            if (unit_s[s]) begin
                res_d.implied_valid = 1'b1;
                res_d.implied_lit   = open_lit[s];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
        end else if (en_i) begin
            result_o <= res_d;   // edge 3, held until the next query
        end
    end

endmodule

//--- design/implication_ctrl.sv
// implication engine control
// LOAD/RUN mode FSM, host write routing to the three stores,
// reject pulse for illegal requests and the query valid pipeline
// that enables the lookup, evaluation and result stages
`timescale 1ns/1ps

module implication_ctrl (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  host_wr_valid_i,
    input  sat_msg_pkg::host_wr_t host_wr_i,
    input  logic                  start_i,
    input  logic                  stop_i,
    input  logic                  query_valid_i,
    output logic                  xlat_we_o,
    output logic                  clause_we_o,
    output logic                  assign_we_o,
    output logic                  lookup_en_o,    // clause table read
    output logic                  eval_en_o,      // result register load
    output logic                  result_valid_o,
    output logic                  reject_o,
    output logic                  run_o
);
    import sat_msg_pkg::*;

    typedef enum logic {
        LOAD = 1'b0,
        RUN  = 1'b1
    } mode_e;

    mode_e      state_q, state_d;
    logic       wr_xlat, wr_clause, wr_assign;   // decoded write targets
    logic       wr_illegal;
    logic       query_ok;
    logic       reject_d;
    logic       reject_q;
    logic [2:0] vld_q;                           // one bit per pipe stage

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOAD: begin
                if (start_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (stop_i) begin
                    state_d = LOAD;
                end
            end
            default: state_d = LOAD;
        endcase
    end

    assign wr_xlat   = host_wr_valid_i && host_wr_i.target == TGT_XLAT;
    assign wr_clause = host_wr_valid_i && host_wr_i.target == TGT_CLAUSE;
    assign wr_assign = host_wr_valid_i && host_wr_i.target == TGT_ASSIGN;

    // tables only in LOAD, assignments any time
    assign xlat_we_o   = wr_xlat && state_q == LOAD;
    assign clause_we_o = wr_clause && state_q == LOAD;
    assign assign_we_o = wr_assign;

    // table write in RUN, or a target code with no store behind it
    assign wr_illegal = ((wr_xlat || wr_clause) && state_q == RUN)
                     || (host_wr_valid_i && !(wr_xlat || wr_clause || wr_assign));
    assign query_ok   = query_valid_i && state_q == RUN;
    assign reject_d   = wr_illegal || (query_valid_i && state_q == LOAD);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= LOAD;
            reject_q <= 1'b0;
            vld_q    <= '0;
        end else begin
            state_q  <= state_d;
            reject_q <= reject_d;                   // one cycle after the strobe
            vld_q    <= {vld_q[1:0], query_ok};     // no stall, shifts every cycle
        end
    end

    assign lookup_en_o    = vld_q[0];   // xlat entry registered at edge 1
    assign eval_en_o      = vld_q[1];   // row and mask registered at edge 2
    assign result_valid_o = vld_q[2];   // result registered at edge 3
    assign reject_o       = reject_q;
    assign run_o          = state_q == RUN;

    // tables are read-only while queries may be in flight,
    // stop_i does not drain the pipe so a quick reload could overlap
    a_no_table_wr_in_flight : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (xlat_we_o || clause_we_o) |-> vld_q == '0)
        else $error("implication_ctrl: table write enable while a query is in flight");

endmodule

//--- design/sat_check_top.sv
// SAT clause-lookup and implication-check engine, top level
// control FSM plus the three-stage lookup / fetch / evaluate datapath
`timescale 1ns/1ps

module sat_check_top #(
    parameter int VAR_ADDR_W = sat_types_pkg::VAR_ADDR_W,
    parameter int SLOTS      = sat_types_pkg::SLOTS
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    host_wr_valid_i,
    input  sat_msg_pkg::host_wr_t   host_wr_i,
    input  logic                    start_i,
    input  logic                    stop_i,
    input  logic                    query_valid_i,
    input  sat_types_pkg::literal_t query_lit_i,
    output logic                    result_valid_o,
    output sat_msg_pkg::result_t    result_o,
    output logic                    reject_o,
    output logic                    run_o
);
    import sat_types_pkg::*;

    localparam int CT_ROW_W = sat_types_pkg::ROW_W;

    logic        xlat_we, clause_we, assign_we;
    logic        lookup_en, eval_en;
    xlat_entry_t xlat_entry;   // stage 1
    clause_row_t ct_row;       // stage 2
    slot_mask_t  ct_mask;
    lit_status_e [SLOTS-1:0][NSAT-2:0] lit_status;

    implication_ctrl u_ctrl (
        .clk_i, .arst_n_i, .host_wr_valid_i, .host_wr_i,
        .start_i, .stop_i, .query_valid_i,
        .xlat_we_o      (xlat_we),
        .clause_we_o    (clause_we),
        .assign_we_o    (assign_we),
        .lookup_en_o    (lookup_en),
        .eval_en_o      (eval_en),
        .result_valid_o, .reject_o, .run_o
    );

    // any query strobe reads, only accepted ones move down the valid pipe
    lit_translate_table #(.VAR_ADDR_W(VAR_ADDR_W), .SLOTS(SLOTS)) u_xlat (
        .clk_i, .arst_n_i,
        .we_i       (xlat_we),
        .wr_lit_i   (host_wr_i.addr),
        .wr_entry_i (host_wr_i.data[$bits(xlat_entry_t)-1:0]),
        .rd_en_i    (query_valid_i),
        .rd_lit_i   (query_lit_i),
        .entry_o    (xlat_entry)
    );

    clause_table #(.SLOTS(SLOTS), .ROW_W(CT_ROW_W)) u_clause (
        .clk_i, .arst_n_i,
        .we_i      (clause_we),
        .wr_row_i  (host_wr_i.addr[CT_ROW_W-1:0]),
        .wr_data_i (host_wr_i.data),
        .rd_en_i   (lookup_en),
        .rd_row_i  (xlat_entry.row),
        .mask_i    (xlat_entry.mask),
        .row_o     (ct_row),
        .mask_o    (ct_mask)
    );

    assign_store #(.VAR_ADDR_W(VAR_ADDR_W), .SLOTS(SLOTS)) u_assign (
        .clk_i, .arst_n_i,
        .we_i     (assign_we),
        .wr_var_i (host_wr_i.addr[VAR_ADDR_W-1:0]),
        .wr_val_i (assign_e'(host_wr_i.data[1:0])),
        .row_i    (ct_row),
        .status_o (lit_status)
    );

    clause_eval #(.SLOTS(SLOTS)) u_eval (
        .clk_i, .arst_n_i,
        .en_i     (eval_en),
        .row_i    (ct_row),
        .mask_i   (ct_mask),
        .status_i (lit_status),
        .result_o
    );

endmodule

//--- sim/tb_sat_check.sv
// testbench for the SAT clause-lookup and implication-check engine
// directed tests against a reference model that keeps its own copy
// of the translate table, clause table and assignment store
`timescale 1ns/1ps

module tb_sat_check;
    import sat_types_pkg::*;
    import sat_msg_pkg::*;

    localparam int S_FALSE = 0;
    localparam int S_TRUE  = 1;
    localparam int S_OPEN  = 2;
    localparam int TIMEOUT = 20;   // cycles to wait for a result

    logic        clk_i, arst_n_i;
    logic        host_wr_valid_i, start_i, stop_i, query_valid_i;
    host_wr_t    host_wr_i;
    literal_t    query_lit_i;
    logic        result_valid_o, reject_o, run_o;
    result_t     result_o;

    // reference model state
    xlat_entry_t m_xlat [2**(VAR_ADDR_W+1)];
    clause_row_t m_rows [2**ROW_W];
    logic [1:0]  m_vals [2**VAR_ADDR_W];   // 0 unassigned, 1 false, 2 true
    logic        run_model;
    logic [31:0] rng;
    int          errors, checks;

    sat_check_top #(.VAR_ADDR_W(VAR_ADDR_W), .SLOTS(SLOTS)) uut (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic literal_t mk_lit(int v, bit n);
        literal_t l;
        l.var_addr = v[VAR_ADDR_W-1:0];
        l.neg      = n;
        return l;
    endfunction

    // literal value per the evaluation rules
    function automatic int lit_state(literal_t l);
        if (m_vals[l.var_addr] == 2'd0) return S_OPEN;
        return ((m_vals[l.var_addr] == 2'd2) != l.neg) ? S_TRUE : S_FALSE;
    endfunction

    function automatic result_t model_result(literal_t q);
        result_t     r;
        clause_row_t row;
        int          a, b;
        r   = '0;
        row = m_rows[m_xlat[q].row];
        for (int s = 0; s < SLOTS; s++) begin
            a = lit_state(row[s].lit[0]);
            b = lit_state(row[s].lit[1]);
            if (!m_xlat[q].mask[s]) continue;        // slot not owned by q
            if (a == S_FALSE && b == S_FALSE) begin
                r.conflict = 1'b1;
            end else if ((a == S_FALSE && b == S_OPEN) || (a == S_OPEN && b == S_FALSE)) begin
                if (!r.implied_valid) begin          // lowest unit slot wins
                    r.implied_valid = 1'b1;
                    r.implied_lit   = (a == S_OPEN) ? row[s].lit[0] : row[s].lit[1];
                end
                r.unit_count = r.unit_count + 3'd1;
            end
        end
        return r;
    endfunction

    task automatic check(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // one write strobe, reject expected only for a table write in RUN
    task automatic host_write(wr_target_e tgt, logic [HOST_ADDR_W-1:0] addr,
                              logic [HOST_DATA_W-1:0] data);
        logic legal;
        legal = (tgt == TGT_ASSIGN) || !run_model;
        @(negedge clk_i);
        host_wr_valid_i  = 1'b1;
        host_wr_i.target = tgt;
        host_wr_i.addr   = addr;
        host_wr_i.data   = data;
        @(negedge clk_i);
        host_wr_valid_i = 1'b0;
        check("write reject", !legal, reject_o);
        if (legal) begin
            case (tgt)
                TGT_XLAT:   m_xlat[addr] = data[$bits(xlat_entry_t)-1:0];
                TGT_CLAUSE: m_rows[addr[ROW_W-1:0]] = data;
                default:    m_vals[addr[VAR_ADDR_W-1:0]] = data[1:0];
            endcase
        end
    endtask

    task automatic set_mode(bit go_run);
        @(negedge clk_i);
        start_i = go_run;
        stop_i  = !go_run;
        @(negedge clk_i);
        start_i   = 1'b0;
        stop_i    = 1'b0;
        run_model = go_run;
        check("run mode", go_run, run_o);
    endtask

    // single query, latency and full result checked against the model
    task automatic run_query(string name, literal_t q, output result_t res);
        result_t exp;
        int      cycles;
        exp = model_result(q);
        @(negedge clk_i);
        query_valid_i = 1'b1;
        query_lit_i   = q;
        cycles        = 0;
        do begin
            @(negedge clk_i);
            query_valid_i = 1'b0;
            cycles++;
        end while (!result_valid_o && cycles < TIMEOUT);
        res = result_o;
        if (!result_valid_o) begin
            errors++;
            $display("query %s got no result within %0d cycles", name, TIMEOUT);
        end else begin
            check({name, " latency"}, 3, cycles);
            check({name, " result"}, exp, res);
        end
    endtask

    task automatic load_tables;
        clause_row_t row;
        xlat_entry_t e;
        row = '0;   // row 1, slot 0 = (x1, x2)
        row[0].lit[0] = mk_lit(1, 0);
        row[0].lit[1] = mk_lit(2, 0);
        host_write(TGT_CLAUSE, 7'd1, row);
        row = '0;   // row 2, conflict slot then unit slot
        row[0].lit[0] = mk_lit(3, 0);
        row[0].lit[1] = mk_lit(4, 1);
        row[1].lit[0] = mk_lit(5, 0);
        row[1].lit[1] = mk_lit(6, 0);
        host_write(TGT_CLAUSE, 7'd2, row);
        row = '0;   // row 3, masked / satisfied / unit / unit
        row[0].lit[0] = mk_lit(7, 0);
        row[0].lit[1] = mk_lit(8, 0);
        row[1].lit[0] = mk_lit(9, 0);
        row[1].lit[1] = mk_lit(10, 0);
        row[2].lit[0] = mk_lit(11, 0);
        row[2].lit[1] = mk_lit(12, 0);
        row[3].lit[0] = mk_lit(13, 1);
        row[3].lit[1] = mk_lit(14, 0);
        host_write(TGT_CLAUSE, 7'd3, row);
        host_write(TGT_XLAT, mk_lit(0, 0), 56'({6'd1, 4'b0001}));
        host_write(TGT_XLAT, mk_lit(0, 1), 56'({6'd2, 4'b0011}));
        host_write(TGT_XLAT, mk_lit(15, 0), 56'({6'd3, 4'b1110}));
        // random rows 4..7 over vars 16..31, reached from literals of vars 32..39
        for (int r = 4; r < 8; r++) begin
            for (int s = 0; s < SLOTS; s++) begin
                for (int l = 0; l < NSAT - 1; l++) begin
                    rng = xorshift32(rng);
                    row[s].lit[l] = mk_lit(16 + rng[3:0], rng[8]);
                end
            end
            host_write(TGT_CLAUSE, 7'(r), row);
        end
        for (int v = 32; v < 40; v++) begin
            for (int n = 0; n < 2; n++) begin
                rng    = xorshift32(rng);
                e.row  = 6'(4 + rng[1:0]);
                e.mask = rng[7:4];
                host_write(TGT_XLAT, mk_lit(v, n), 56'(e));
            end
        end
    endtask

    task automatic test_reset;
        check("reset run_o", 0, run_o);
        check("reset result_valid_o", 0, result_valid_o);
        check("reset reject_o", 0, reject_o);
    endtask

    task automatic test_unit;
        result_t res;
        host_write(TGT_ASSIGN, 7'd1, 56'(VAL_FALSE));
        run_query("unit", mk_lit(0, 0), res);
        check("unit count", 1, res.unit_count);
        check("unit implied", mk_lit(2, 0), res.implied_lit);
        check("unit conflict", 0, res.conflict);
    endtask

    task automatic test_conflict;
        result_t res;
        host_write(TGT_ASSIGN, 7'd3, 56'(VAL_FALSE));
        host_write(TGT_ASSIGN, 7'd4, 56'(VAL_TRUE));   // ~x4 false
        host_write(TGT_ASSIGN, 7'd5, 56'(VAL_FALSE));
        run_query("conflict", mk_lit(0, 1), res);
        check("conflict flag", 1, res.conflict);
        check("conflict unit count", 1, res.unit_count);
        check("conflict implied", mk_lit(6, 0), res.implied_lit);
    endtask

    task automatic test_mask_sat;
        result_t res;
        host_write(TGT_ASSIGN, 7'd7, 56'(VAL_FALSE));
        host_write(TGT_ASSIGN, 7'd8, 56'(VAL_FALSE));   // would conflict, masked off
        host_write(TGT_ASSIGN, 7'd9, 56'(VAL_TRUE));
        host_write(TGT_ASSIGN, 7'd11, 56'(VAL_FALSE));
        host_write(TGT_ASSIGN, 7'd14, 56'(VAL_FALSE));
        run_query("mask", mk_lit(15, 0), res);
        check("mask conflict", 0, res.conflict);
        check("mask unit count", 2, res.unit_count);
        check("mask implied", mk_lit(12, 0), res.implied_lit);
    endtask

    task automatic test_pipeline;
        result_t exp_q[$];
        int      issue_q[$];
        literal_t q;
        for (int v = 16; v < 32; v++) begin
            rng = xorshift32(rng);
            host_write(TGT_ASSIGN, 7'(v), 56'(rng % 3));
        end
        for (int c = 0; c < 16 + TIMEOUT; c++) begin
            @(negedge clk_i);
            if (result_valid_o) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("burst produced a result with no query in flight");
                end else begin
                    check("burst latency", issue_q.pop_front() + 3, c);
                    check("burst result", exp_q.pop_front(), result_o);
                end
            end
            query_valid_i = (c < 16);   // 16 queries on consecutive cycles
            if (c < 16) begin
                rng = xorshift32(rng);
                q   = mk_lit(32 + rng[2:0], rng[5]);
                query_lit_i = q;
                exp_q.push_back(model_result(q));
                issue_q.push_back(c);
            end
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("burst ended with %0d results missing", exp_q.size());
        end
    endtask

    task automatic test_mode;
        result_t     res;
        clause_row_t row;
        int          seen;
        row = '0;
        row[0].lit[0] = mk_lit(20, 0);
        row[0].lit[1] = mk_lit(21, 0);
        host_write(TGT_CLAUSE, 7'd1, row);              // rejected in RUN
        run_query("old row", mk_lit(0, 0), res);
        check("old row implied", mk_lit(2, 0), res.implied_lit);
        host_write(TGT_ASSIGN, 7'd2, 56'(VAL_TRUE));     // accepted in RUN
        run_query("run assign", mk_lit(0, 0), res);
        check("run assign unit count", 0, res.unit_count);
        set_mode(1'b0);
        seen = 0;
        @(negedge clk_i);
        query_valid_i = 1'b1;
        query_lit_i   = mk_lit(0, 0);
        @(negedge clk_i);
        query_valid_i = 1'b0;
        check("load query reject", 1, reject_o);
        for (int i = 0; i < 6; i++) begin
            @(negedge clk_i);
            if (result_valid_o) seen++;
        end
        if (seen != 0) begin
            errors++;
            $display("query in LOAD mode produced a result");
        end
    endtask

    initial begin
        clk_i = 1'b0;
        arst_n_i = 1'b0;
        host_wr_valid_i = 1'b0;
        host_wr_i = '0;
        start_i = 1'b0;
        stop_i = 1'b0;
        query_valid_i = 1'b0;
        query_lit_i = '0;
        run_model = 1'b0;
        rng = 32'd39594;
        errors = 0;
        checks = 0;
        foreach (m_xlat[i]) m_xlat[i] = '0;
        foreach (m_rows[i]) m_rows[i] = '0;
        foreach (m_vals[i]) m_vals[i] = 2'd0;
        repeat (2) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);
        test_reset();
        load_tables();
        set_mode(1'b1);
        test_unit();
        test_conflict();
        test_mask_sat();
        test_pipeline();
        test_mode();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
design/sat_types_pkg.sv
design/sat_msg_pkg.sv
design/lit_translate_table.sv
design/clause_table.sv
design/assign_store.sv
design/clause_eval.sv
design/implication_ctrl.sv
design/sat_check_top.sv
sim/tb_sat_check.sv
